//--- source/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  csr_op_t;

    // Operation codes handed from decode to execute
    localparam csr_op_t OP_NONE  = 3'd0;
    localparam csr_op_t OP_RW    = 3'd1;
    localparam csr_op_t OP_RS    = 3'd2;
    localparam csr_op_t OP_RC    = 3'd3;
    localparam csr_op_t OP_ECALL = 3'd4;
    localparam csr_op_t OP_MRET  = 3'd5;

    // Machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;

    localparam word_t MVENDORID_VALUE = 32'h79737978;
    localparam word_t MARCHID_VALUE   = 32'h23060124;

    // Environment call from M-mode
    localparam word_t MCAUSE_ECALL_M = 32'd11;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // Full encodings of the two privileged instructions handled here
    localparam word_t INSTR_ECALL = 32'h00000073;
    localparam word_t INSTR_MRET  = 32'h30200073;

endpackage

//--- source/sys_op_if.sv
`timescale 1ns/100ps

interface sys_op_if
    import csr_pkg::*;
();

    logic      valid;
    csr_op_t   op;
    csr_addr_t csr_addr;
    reg_idx_t  rd;
    word_t     src;
    // rs1 field is x0 or the immediate is zero
    logic      src_zero;
    word_t     pc;

    modport producer (
        output valid, op, csr_addr, rd, src, src_zero, pc
    );

    modport consumer (
        input valid, op, csr_addr, rd, src, src_zero, pc
    );

endinterface

//--- source/sys_decode.sv
`timescale 1ns/100ps

module sys_decode
    import csr_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       i_valid,
    input  word_t      i_instr,
    input  word_t      i_pc,
    input  word_t      i_rs1_data,
    sys_op_if.producer o_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd_idx;
    reg_idx_t   rs1_idx;
    csr_addr_t  csr_addr;
    csr_op_t    op_next;
    word_t      src_next;

    assign opcode   = i_instr[6:0];
    assign rd_idx   = i_instr[11:7];
    assign funct3   = i_instr[14:12];
    assign rs1_idx  = i_instr[19:15];
    assign csr_addr = i_instr[31:20];

    // funct3[1:0] picks the CSR access kind, funct3[2] the immediate form
    always_comb begin
        op_next = OP_NONE;
        if (i_instr == INSTR_ECALL) begin
            op_next = OP_ECALL;
        end else if (i_instr == INSTR_MRET) begin
            op_next = OP_MRET;
        end else if (opcode == OPCODE_SYSTEM) begin
            case (funct3[1:0])
                2'b01:   op_next = OP_RW;
                2'b10:   op_next = OP_RS;
                2'b11:   op_next = OP_RC;
                default: op_next = OP_NONE;
            endcase
        end
    end

    // Zero-extended uimm sits in the rs1 field
    assign src_next = funct3[2] ? {27'd0, rs1_idx} : i_rs1_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            o_op.valid <= 1'b0;
        end else begin
            o_op.valid <= i_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (i_valid) begin
            o_op.op       <= op_next;
            o_op.csr_addr <= csr_addr;
            o_op.rd       <= rd_idx;
            o_op.src      <= src_next;
            o_op.src_zero <= (rs1_idx == 5'd0);
            o_op.pc       <= i_pc;
        end
    end

endmodule

//--- source/csr_register_file.sv
`timescale 1ns/100ps

module csr_register_file
    import csr_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      i_csr_wen,
    input  csr_addr_t i_csr_waddr,
    input  word_t     i_csr_wdata,
    input  csr_addr_t i_csr_raddr,
    output word_t     o_csr_rdata,
    input  logic      i_ecall,
    input  logic      i_mret,
    input  word_t     i_pc,
    output logic      o_redirect,
    output word_t     o_redirect_pc
);

    word_t mstatus;
    word_t mepc;
    word_t mcause;
    word_t mtvec;

    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus <= '0;
            mepc    <= '0;
            mcause  <= MCAUSE_ECALL_M;
            mtvec   <= '0;
        end else if (i_ecall) begin
            mepc   <= i_pc;
            mcause <= MCAUSE_ECALL_M;
            // Stack MIE into MPIE and enter M-mode with interrupts off
            mstatus[MSTATUS_MPIE]         <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]          <= 1'b0;
            mstatus[MSTATUS_MPP_LO +: 2]  <= 2'b11;
        end else if (i_mret) begin
            mstatus[MSTATUS_MIE]          <= mstatus[MSTATUS_MPIE];
            mstatus[MSTATUS_MPIE]         <= 1'b1;
            mstatus[MSTATUS_MPP_LO +: 2]  <= 2'b00;
        end else if (i_csr_wen) begin
            case (i_csr_waddr)
                CSR_MSTATUS: mstatus <= i_csr_wdata;
                CSR_MEPC:    mepc    <= i_csr_wdata;
                CSR_MCAUSE:  mcause  <= i_csr_wdata;
                CSR_MTVEC:   mtvec   <= i_csr_wdata;
                default: begin
                end
            endcase
        end
    end

    // Identity registers are constants, unmapped space reads zero
    always_comb begin
        case (i_csr_raddr)
            CSR_MVENDORID: o_csr_rdata = MVENDORID_VALUE;
            CSR_MARCHID:   o_csr_rdata = MARCHID_VALUE;
            CSR_MSTATUS:   o_csr_rdata = mstatus;
            CSR_MEPC:      o_csr_rdata = mepc;
            CSR_MCAUSE:    o_csr_rdata = mcause;
            CSR_MTVEC:     o_csr_rdata = mtvec;
            default:       o_csr_rdata = '0;
        endcase
    end

    // Target comes from the pre-update value
    assign o_redirect    = i_ecall | i_mret;
    assign o_redirect_pc = i_ecall ? mtvec : mepc;

endmodule

//--- source/csr_execute.sv
`timescale 1ns/100ps

module csr_execute
    import csr_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    sys_op_if.consumer i_op,
    output logic       o_valid,
    output logic       o_rd_wen,
    output reg_idx_t   o_rd_addr,
    output word_t      o_rd_data,
    output logic       o_redirect,
    output word_t      o_redirect_pc
);

    logic  is_csr_op;
    logic  csr_wen;
    word_t csr_rdata;
    word_t csr_wdata;
    logic  ecall;
    logic  mret;
    logic  redirect;
    word_t redirect_pc;

    assign is_csr_op = i_op.valid &&
                       ((i_op.op == OP_RW) || (i_op.op == OP_RS) || (i_op.op == OP_RC));

    assign ecall = i_op.valid && (i_op.op == OP_ECALL);
    assign mret  = i_op.valid && (i_op.op == OP_MRET);

    always_comb begin
        case (i_op.op)
            OP_RS:   csr_wdata = csr_rdata | i_op.src;
            OP_RC:   csr_wdata = csr_rdata & ~i_op.src;
            default: csr_wdata = i_op.src;
        endcase
    end

    // Set and clear with a zero source leave the CSR untouched
    assign csr_wen = is_csr_op && ((i_op.op == OP_RW) || !i_op.src_zero);

    csr_register_file u_csr_register_file (
        .clock         (clock),
        .reset         (reset),
        .i_csr_wen     (csr_wen),
        .i_csr_waddr   (i_op.csr_addr),
        .i_csr_wdata   (csr_wdata),
        .i_csr_raddr   (i_op.csr_addr),
        .o_csr_rdata   (csr_rdata),
        .i_ecall       (ecall),
        .i_mret        (mret),
        .i_pc          (i_op.pc),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            o_valid    <= 1'b0;
            o_rd_wen   <= 1'b0;
            o_redirect <= 1'b0;
        end else begin
            o_valid    <= i_op.valid;
            o_rd_wen   <= is_csr_op && (i_op.rd != 5'd0);
            o_redirect <= redirect;
        end
    end

    // Retire payload, meaningful only alongside the strobes above
    always_ff @(posedge clock) begin
        if (i_op.valid) begin
            o_rd_addr     <= i_op.rd;
            o_rd_data     <= csr_rdata;
            o_redirect_pc <= redirect_pc;
        end
    end

endmodule

//--- source/csr_pipe.sv
`timescale 1ns/100ps

module csr_pipe
    import csr_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     i_valid,
    input  word_t    i_instr,
    input  word_t    i_pc,
    input  word_t    i_rs1_data,
    output logic     o_valid,
    output logic     o_rd_wen,
    output reg_idx_t o_rd_addr,
    output word_t    o_rd_data,
    output logic     o_redirect,
    output word_t    o_redirect_pc
);

    // Decoded operation between the two stages
    sys_op_if u_op_if ();

    sys_decode u_sys_decode (
        .clock      (clock),
        .reset      (reset),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .o_op       (u_op_if.producer)
    );

    csr_execute u_csr_execute (
        .clock         (clock),
        .reset         (reset),
        .i_op          (u_op_if.consumer),
        .o_valid       (o_valid),
        .o_rd_wen      (o_rd_wen),
        .o_rd_addr     (o_rd_addr),
        .o_rd_data     (o_rd_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

endmodule

//--- include/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Expects csr_pkg to be imported by the including module
typedef struct packed {
    logic     rd_wen;
    reg_idx_t rd_addr;
    word_t    rd_data;
    logic     redirect;
    word_t    redirect_pc;
} retire_rec_t;

word_t ref_mstatus;
word_t ref_mepc;
word_t ref_mcause;
word_t ref_mtvec;

function automatic void reset_model();
    ref_mstatus = '0;
    ref_mepc    = '0;
    ref_mcause  = MCAUSE_ECALL_M;
    ref_mtvec   = '0;
endfunction

function automatic word_t read_model_csr(csr_addr_t addr);
    case (addr)
        CSR_MVENDORID: return MVENDORID_VALUE;
        CSR_MARCHID:   return MARCHID_VALUE;
        CSR_MSTATUS:   return ref_mstatus;
        CSR_MEPC:      return ref_mepc;
        CSR_MCAUSE:    return ref_mcause;
        CSR_MTVEC:     return ref_mtvec;
        default:       return '0;
    endcase
endfunction

function automatic void write_model_csr(csr_addr_t addr, word_t data);
    case (addr)
        CSR_MSTATUS: ref_mstatus = data;
        CSR_MEPC:    ref_mepc    = data;
        CSR_MCAUSE:  ref_mcause  = data;
        CSR_MTVEC:   ref_mtvec   = data;
        default: begin
        end
    endcase
endfunction

// Applies one instruction in program order and returns its retire record
function automatic retire_rec_t apply_instr(word_t instr, word_t pc, word_t rs1_data);
    retire_rec_t rec;
    logic [2:0]  funct3;
    reg_idx_t    rs1_idx;
    csr_addr_t   addr;
    word_t       old_value;
    word_t       src;
    funct3  = instr[14:12];
    rs1_idx = instr[19:15];
    addr    = instr[31:20];
    rec     = '0;
    rec.rd_addr = instr[11:7];
    if (instr == INSTR_ECALL) begin
        rec.redirect    = 1'b1;
        rec.redirect_pc = ref_mtvec;
        ref_mepc   = pc;
        ref_mcause = MCAUSE_ECALL_M;
        ref_mstatus[MSTATUS_MPIE]        = ref_mstatus[MSTATUS_MIE];
        ref_mstatus[MSTATUS_MIE]         = 1'b0;
        ref_mstatus[MSTATUS_MPP_LO +: 2] = 2'b11;
    end else if (instr == INSTR_MRET) begin
        rec.redirect    = 1'b1;
        rec.redirect_pc = ref_mepc;
        ref_mstatus[MSTATUS_MIE]         = ref_mstatus[MSTATUS_MPIE];
        ref_mstatus[MSTATUS_MPIE]        = 1'b1;
        ref_mstatus[MSTATUS_MPP_LO +: 2] = 2'b00;
    end else if (instr[6:0] == OPCODE_SYSTEM && funct3[1:0] != 2'b00) begin
        old_value   = read_model_csr(addr);
        src         = funct3[2] ? {27'd0, rs1_idx} : rs1_data;
        rec.rd_wen  = (rec.rd_addr != 5'd0);
        rec.rd_data = old_value;
        if (funct3[1:0] == 2'b01) begin
            write_model_csr(addr, src);
        end else if (rs1_idx != 5'd0) begin
            if (funct3[1:0] == 2'b10) begin
                write_model_csr(addr, old_value | src);
            end else begin
                write_model_csr(addr, old_value & ~src);
            end
        end
    end
    return rec;
endfunction

`endif

//--- verification/csr_pipe_tb.sv
`timescale 1ns/100ps

module csr_pipe_tb
    import csr_pkg::*;
();

    `include "csr_ref_model.svh"

    localparam int NUM_INSTR = 400;
    localparam int DRAIN_LIMIT = 20;

    logic     clock;
    logic     reset;
    logic     i_valid;
    word_t    i_instr;
    word_t    i_pc;
    word_t    i_rs1_data;
    logic     o_valid;
    logic     o_rd_wen;
    reg_idx_t o_rd_addr;
    word_t    o_rd_data;
    logic     o_redirect;
    word_t    o_redirect_pc;

    integer       seed;
    integer       errors;
    integer       cycle;
    integer       wait_cycles;
    retire_rec_t  expected_q[$];
    integer       issue_q[$];

    csr_pipe uut (
        .clock         (clock),
        .reset         (reset),
        .i_valid       (i_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_rs1_data    (i_rs1_data),
        .o_valid       (o_valid),
        .o_rd_wen      (o_rd_wen),
        .o_rd_addr     (o_rd_addr),
        .o_rd_data     (o_rd_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Six mapped CSRs plus one unmapped address
    function automatic csr_addr_t csr_addr_at(int idx);
        case (idx)
            0:       return CSR_MSTATUS;
            1:       return CSR_MTVEC;
            2:       return CSR_MEPC;
            3:       return CSR_MCAUSE;
            4:       return CSR_MVENDORID;
            5:       return CSR_MARCHID;
            default: return 12'h7C0;
        endcase
    endfunction

    function automatic csr_addr_t pick_addr();
        return csr_addr_at($unsigned($random(seed)) % 7);
    endfunction

    function automatic word_t random_instr();
        integer     kind;
        logic [2:0] funct3;
        reg_idx_t   rs1;
        reg_idx_t   rd;
        csr_addr_t  addr;
        kind = $unsigned($random(seed)) % 16;
        rd   = reg_idx_t'($random(seed));
        rs1  = (($random(seed) & 3) == 0) ? 5'd0 : reg_idx_t'($random(seed));
        addr = pick_addr();
        case ($unsigned($random(seed)) % 6)
            0:       funct3 = 3'd1;
            1:       funct3 = 3'd2;
            2:       funct3 = 3'd3;
            3:       funct3 = 3'd5;
            4:       funct3 = 3'd6;
            default: funct3 = 3'd7;
        endcase
        case (kind)
            12, 13:  return INSTR_ECALL;
            14:      return INSTR_MRET;
            // wfi, which this path treats as no operation
            15:      return 32'h10500073;
            default: return {addr, rs1, funct3, rd, OPCODE_SYSTEM};
        endcase
    endfunction

    task automatic drive_instr(logic valid, word_t instr, word_t pc, word_t rs1_data);
        retire_rec_t rec;
        i_valid    = valid;
        i_instr    = instr;
        i_pc       = pc;
        i_rs1_data = rs1_data;
        if (valid) begin
            rec = apply_instr(instr, pc, rs1_data);
            expected_q.push_back(rec);
            issue_q.push_back(cycle);
        end
    endtask

    task automatic drive_next();
        logic  valid;
        word_t instr;
        word_t pc;
        word_t rs1_data;
        valid    = (($random(seed) & 7) != 0);
        instr    = random_instr();
        pc       = $random(seed) & 32'hFFFF_FFFC;
        rs1_data = $random(seed);
        drive_instr(valid, instr, pc, rs1_data);
    endtask

    task automatic check_retire();
        retire_rec_t expected;
        integer      issued;
        if (o_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("%0t ns: o_valid is high with no instruction in flight", $time);
                errors++;
            end else begin
                expected = expected_q.pop_front();
                issued   = issue_q.pop_front();
                if (cycle - issued != 2) begin
                    $display("Mismatch at %0t ns: latency %0d cycles, expected 2",
                             $time, cycle - issued);
                    errors++;
                end
                if (o_rd_wen !== expected.rd_wen) begin
                    $display("Mismatch at %0t ns: rd_wen %b, expected %b",
                             $time, o_rd_wen, expected.rd_wen);
                    errors++;
                end
                if (expected.rd_wen && (o_rd_addr !== expected.rd_addr ||
                                        o_rd_data !== expected.rd_data)) begin
                    $display("Mismatch at %0t ns: rd x%0d = %h, expected x%0d = %h", $time,
                             o_rd_addr, o_rd_data, expected.rd_addr, expected.rd_data);
                    errors++;
                end
                if (o_redirect !== expected.redirect) begin
                    $display("Mismatch at %0t ns: redirect %b, expected %b",
                             $time, o_redirect, expected.redirect);
                    errors++;
                end
                if (expected.redirect && o_redirect_pc !== expected.redirect_pc) begin
                    $display("Mismatch at %0t ns: redirect pc %h, expected %h",
                             $time, o_redirect_pc, expected.redirect_pc);
                    errors++;
                end
            end
        end else if (!reset && o_valid !== 1'b0) begin
            $display("%0t ns: o_valid is unknown after reset", $time);
            errors++;
        end else if (issue_q.size() != 0 && cycle - issue_q[0] >= 2) begin
            $display("%0t ns: instruction issued in cycle %0d never retired", $time, issue_q[0]);
            errors++;
            void'(expected_q.pop_front());
            void'(issue_q.pop_front());
        end
    endtask

    // Outputs are stable halfway through the cycle
    always @(negedge clock) begin
        check_retire();
    end

    initial begin
        reset_model();
        seed       = 32'he9f15f37;
        errors     = 0;
        cycle      = 0;
        clock      = 1'b0;
        reset      = 1'b1;
        i_valid    = 1'b0;
        i_instr    = '0;
        i_pc       = '0;
        i_rs1_data = '0;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        // Read every address once so reset values and constants are seen
        for (int a = 0; a < 7; a++) begin
            @(posedge clock);
            #2;
            drive_instr(1'b1, {csr_addr_at(a), 5'd0, 3'd2, 5'd1, OPCODE_SYSTEM}, '0, '0);
        end
        for (int n = 0; n < NUM_INSTR; n++) begin
            @(posedge clock);
            #2;
            drive_next();
        end
        @(posedge clock);
        #2;
        i_valid = 1'b0;
        wait_cycles = 0;
        while (expected_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(posedge clock);
            wait_cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("Timeout: %0d retire records never arrived", expected_q.size());
            errors++;
        end
        repeat (2) @(posedge clock);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- csr_pipe.f
+incdir+include
source/csr_pkg.sv
source/sys_op_if.sv
source/sys_decode.sv
source/csr_register_file.sv
source/csr_execute.sv
source/csr_pipe.sv
verification/csr_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f csr_pipe.f --top-module csr_pipe_tb -o csr_pipe_sim
sim_output=$(./obj_dir/csr_pipe_sim)
echo "$sim_output"

if echo "$sim_output" | grep -q "Done: no errors"; then
    exit 0
else
    exit 1
fi
